// File: Makefile
# Verilator build and run of the memory system testbench

VERILATOR ?= verilator
TOP       ?= mem_sys_tb
FILELIST  ?= mem_sys.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "No errors"

clean:
	rm -rf $(OBJ_DIR)

// File: bench/axil_mem_model.sv
// AXI-Lite slave for simulation only; 256 words, addresses at or above 0x300 answer SLVERR
`timescale 1ns/100ps
`include "mem_sys_settings.svh"

module axil_mem_model
	import mem_sys_pkg::*;
(
	input  logic       m_axil_clk,
	input  logic       rst_n,
	input  addr_t      awaddr,
	input  logic       awvalid,
	output logic       awready,
	input  data_t      wdata,
	input  strb_t      wstrb,
	input  logic       wvalid,
	output logic       wready,
	output axil_resp_t bresp,
	output logic       bvalid,
	input  logic       bready,
	input  addr_t      araddr,
	input  logic       arvalid,
	output logic       arready,
	output data_t      rdata,
	output axil_resp_t rresp,
	output logic       rvalid,
	input  logic       rready
);

	localparam int    WORDS    = 256;
	localparam addr_t ERR_BASE = 32'h0000_0300;

	data_t  mem [0:WORDS-1];
	integer seed;

	// Each word differs in every byte with its index
	function automatic data_t fill_word(input int i);
		logic [7:0] k;
		k = i[7:0];
		return {k ^ 8'h3c, k ^ 8'ha5, ~k, k};
	endfunction

	function automatic int pick_delay();
		return int'({$random(seed)} % 4); // 0 to 3 cycles
	endfunction

	initial begin
		seed    = 32'he3020d02;
		awready = 1'b0;
		wready  = 1'b0;
		bvalid  = 1'b0;
		bresp   = 2'b00;
		arready = 1'b0;
		rvalid  = 1'b0;
		rresp   = 2'b00;
		rdata   = '0;
		for (int i = 0; i < WORDS; i++)
			mem[i] = fill_word(i);
	end

	////////////////////////////////////////////////////////////////////////////
	// Write side, aw and w accepted independently
	////////////////////////////////////////////////////////////////////////////

	always begin : write_side
		int    d_aw;
		int    d_w;
		addr_t a;
		data_t wd;
		strb_t st;
		@(negedge m_axil_clk);
		if (rst_n && awvalid) begin
			d_aw = pick_delay();
			d_w  = pick_delay();
			a    = awaddr;
			wd   = wdata;
			st   = wstrb;
			fork
				begin
					repeat (d_aw) @(negedge m_axil_clk);
					awready = 1'b1;
					@(negedge m_axil_clk);
					awready = 1'b0;
				end
				begin
					repeat (d_w) @(negedge m_axil_clk);
					wready = 1'b1;
					@(negedge m_axil_clk);
					wready = 1'b0;
				end
			join
			if (a < ERR_BASE) begin
				for (int b = 0; b < 4; b++)
					if (st[b])
						mem[a[9:2]][8*b +: 8] = wd[8*b +: 8];
			end
			repeat (pick_delay()) @(negedge m_axil_clk);
			bresp  = (a < ERR_BASE) ? 2'b00 : 2'b10;
			bvalid = 1'b1;
			while (!bready) @(negedge m_axil_clk); // Ready seen here holds to the next edge
			@(negedge m_axil_clk);
			bvalid = 1'b0;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Read side
	////////////////////////////////////////////////////////////////////////////

	always begin : read_side
		addr_t a;
		@(negedge m_axil_clk);
		if (rst_n && arvalid) begin
			a = araddr;
			repeat (pick_delay()) @(negedge m_axil_clk);
			arready = 1'b1;
			@(negedge m_axil_clk);
			arready = 1'b0;
			repeat (pick_delay()) @(negedge m_axil_clk);
			rdata  = mem[a[9:2]];
			rresp  = (a < ERR_BASE) ? 2'b00 : 2'b10;
			rvalid = 1'b1;
			while (!rready) @(negedge m_axil_clk);
			@(negedge m_axil_clk);
			rvalid = 1'b0;
		end
	end

endmodule

// File: bench/mem_sys_tb.sv
// Drives both ports on the falling edge; memory init must match the slave model fill pattern
`timescale 1ns/100ps
`include "mem_sys_settings.svh"

module mem_sys_tb
	import mem_sys_pkg::*;
();

	localparam int    N_WORD  = 40;
	localparam int    N_SUB   = 60;
	localparam int    N_CONC  = 30;
	localparam int    N_MIS   = 10;
	localparam int    N_ERR   = 14;
	localparam int    N_FINAL = 40;
	localparam int    N_OPS   = 2*N_WORD + N_SUB + 2*N_CONC + 2*N_MIS + N_ERR + N_FINAL;
	localparam int    LIMIT   = N_OPS * 40 + 16;
	localparam addr_t ERR_BASE = 32'h0000_0300;

	logic       m_axil_clk;
	logic       rst_n;
	addr_t      fetch_addr;
	logic       fetch_valid;
	word_rsp_t  fetch_rsp;
	logic       fetch_done;
	data_req_t  data_req;
	logic       data_valid;
	word_rsp_t  data_rsp;
	logic       data_done;
	addr_t      awaddr;
	logic [2:0] awprot;
	logic       awvalid;
	logic       awready;
	data_t      wdata;
	strb_t      wstrb;
	logic       wvalid;
	logic       wready;
	axil_resp_t bresp;
	logic       bvalid;
	logic       bready;
	addr_t      araddr;
	logic [2:0] arprot;
	logic       arvalid;
	logic       arready;
	data_t      rdata;
	axil_resp_t rresp;
	logic       rvalid;
	logic       rready;

	logic [7:0] ref_mem [0:1023];     // Byte model of the slave memory
	integer     seed;
	int         cycles;
	logic       data_busy;
	logic       fetch_busy;
	logic       mis_active;
	logic       both_active;
	int         fetch_since;          // Fetch completions since the last data completion
	int         data_since;

	mem_sys u_dut (
		.m_axil_clk (m_axil_clk), .rst_n (rst_n),
		.fetch_addr (fetch_addr), .fetch_valid (fetch_valid),
		.fetch_rsp (fetch_rsp), .fetch_done (fetch_done),
		.data_req (data_req), .data_valid (data_valid),
		.data_rsp (data_rsp), .data_done (data_done),
		.m_axil_awaddr (awaddr), .m_axil_awprot (awprot),
		.m_axil_awvalid (awvalid), .m_axil_awready (awready),
		.m_axil_wdata (wdata), .m_axil_wstrb (wstrb),
		.m_axil_wvalid (wvalid), .m_axil_wready (wready),
		.m_axil_bresp (bresp), .m_axil_bvalid (bvalid), .m_axil_bready (bready),
		.m_axil_araddr (araddr), .m_axil_arprot (arprot),
		.m_axil_arvalid (arvalid), .m_axil_arready (arready),
		.m_axil_rdata (rdata), .m_axil_rresp (rresp),
		.m_axil_rvalid (rvalid), .m_axil_rready (rready)
	);

	axil_mem_model u_mem (
		.m_axil_clk (m_axil_clk), .rst_n (rst_n),
		.awaddr (awaddr), .awvalid (awvalid), .awready (awready),
		.wdata (wdata), .wstrb (wstrb), .wvalid (wvalid), .wready (wready),
		.bresp (bresp), .bvalid (bvalid), .bready (bready),
		.araddr (araddr), .arvalid (arvalid), .arready (arready),
		.rdata (rdata), .rresp (rresp), .rvalid (rvalid), .rready (rready)
	);

	initial begin
		m_axil_clk = 1'b0;
		forever #4 m_axil_clk = ~m_axil_clk;
	end

	////////////////////////////////////////////////////////////////////////////
	// Checking helpers
	////////////////////////////////////////////////////////////////////////////

	task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
			input string what);
		if (got !== exp) begin
			$display("** Error at %0t ns: %s, got %h expected %h", $time, what, got, exp);
			$display("Errors found");
			$fatal(1);
		end
	endtask

	task automatic fail_run(input string what);
		$display("%s at %0t ns", what, $time);
		$display("Errors found");
		$fatal(1);
	endtask

	function automatic int rand_below(input int n);
		return int'({$random(seed)} % n);
	endfunction

	function automatic logic is_misaligned(input addr_t a, input mem_size_t sz);
		if (sz == `MEM_SIZE_BYTE)
			return 1'b0;
		else if (sz == `MEM_SIZE_HALF)
			return a[0];
		else
			return a[1:0] != 2'b00;
	endfunction

	function automatic int size_bytes(input mem_size_t sz);
		if (sz == `MEM_SIZE_BYTE)
			return 1;
		else if (sz == `MEM_SIZE_HALF)
			return 2;
		else
			return 4;
	endfunction

	function automatic data_t expected_load(input addr_t a, input mem_size_t sz, input logic uns);
		int    b;
		data_t w;
		b = int'(a[9:0]);
		w = {ref_mem[(b+3) % 1024], ref_mem[(b+2) % 1024], ref_mem[(b+1) % 1024], ref_mem[b]};
		if (sz == `MEM_SIZE_BYTE)
			return uns ? {24'b0, w[7:0]} : {{24{w[7]}}, w[7:0]};
		else if (sz == `MEM_SIZE_HALF)
			return uns ? {16'b0, w[15:0]} : {{16{w[15]}}, w[15:0]};
		return w;
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Port drivers
	////////////////////////////////////////////////////////////////////////////

	task automatic data_op(input addr_t a, input data_t wd, input mem_size_t sz,
			input logic uns, input logic wr);
		word_rsp_t rsp;
		logic      exp_err;
		exp_err             = is_misaligned(a, sz) || (a >= ERR_BASE);
		mis_active          = is_misaligned(a, sz);
		data_req.addr       = a;
		data_req.wdata      = wd;
		data_req.size       = sz;
		data_req.is_unsigned = uns;
		data_req.wr         = wr;
		data_valid          = 1'b1;
		data_busy           = 1'b1;
		do @(negedge m_axil_clk); while (!data_done);
		rsp        = data_rsp;
		data_valid = 1'b0;
		@(negedge m_axil_clk);
		check_value(32'(data_done), 32'd0, "data done held past one cycle");
		data_busy  = 1'b0;
		mis_active = 1'b0;
		check_value(32'(rsp.err), 32'(exp_err), "data response err");
		if (!exp_err) begin
			if (wr) begin
				for (int i = 0; i < size_bytes(sz); i++)
					ref_mem[int'(a[9:0]) + i] = wd[8*i +: 8];
			end else begin
				check_value(rsp.rdata, expected_load(a, sz, uns), "load data");
			end
		end
	endtask

	task automatic fetch_op(input addr_t a);
		word_rsp_t rsp;
		logic      exp_err;
		exp_err     = a >= ERR_BASE;
		fetch_addr  = a;
		fetch_valid = 1'b1;
		fetch_busy  = 1'b1;
		do @(negedge m_axil_clk); while (!fetch_done);
		rsp         = fetch_rsp;
		fetch_valid = 1'b0;
		@(negedge m_axil_clk);
		check_value(32'(fetch_done), 32'd0, "fetch done held past one cycle");
		fetch_busy = 1'b0;
		check_value(32'(rsp.err), 32'(exp_err), "fetch response err");
		if (!exp_err)
			check_value(rsp.rdata, expected_load(a, `MEM_SIZE_WORD, 1'b0), "fetch data");
	endtask

	// Random aligned or unaligned sub-word access below the given byte limit
	task automatic random_access(input int limit);
		mem_size_t sz;
		addr_t     a;
		sz = mem_size_t'(rand_below(3));
		a  = addr_t'(rand_below(limit));
		if (sz == `MEM_SIZE_HALF)
			a[0] = 1'b0;
		else if (sz == `MEM_SIZE_WORD)
			a[1:0] = 2'b00;
		data_op(a, $random(seed), sz, 1'(rand_below(2)), 1'(rand_below(2)));
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Monitors and timeout
	////////////////////////////////////////////////////////////////////////////

	always @(negedge m_axil_clk) begin
		if (data_done && !data_busy)
			fail_run("data done pulsed with no data request pending");
		if (fetch_done && !fetch_busy)
			fail_run("fetch done pulsed with no fetch request pending");
		if (mis_active && (awvalid || arvalid))
			fail_run("bus request issued for a misaligned access");
		if (awvalid)
			check_value(32'(awprot), 32'(`MEM_AXIL_PROT), "write address protection");
		if (arvalid)
			check_value(32'(arprot), 32'(`MEM_AXIL_PROT), "read address protection");
		if (fetch_done) begin
			data_since  = 0;
			fetch_since = fetch_since + 1;
		end
		if (data_done) begin
			fetch_since = 0;
			data_since  = data_since + 1;
		end
		if (both_active && (fetch_since > 2 || data_since > 2))
			fail_run("one port completed three accesses while the other waited");
	end

	always @(posedge m_axil_clk) begin
		cycles = cycles + 1;
		if (cycles >= LIMIT)
			fail_run("Timeout, a request never completed");
	end

	////////////////////////////////////////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////////////////////////////////////////

	initial begin
		addr_t a;
		seed        = 32'he3020d02;
		cycles      = 0;
		rst_n       = 1'b0;
		fetch_addr  = '0;
		fetch_valid = 1'b0;
		data_req    = '0;
		data_valid  = 1'b0;
		data_busy   = 1'b0;
		fetch_busy  = 1'b0;
		mis_active  = 1'b0;
		both_active = 1'b0;
		fetch_since = 0;
		data_since  = 0;
		for (int i = 0; i < 256; i++) begin // Same fill as the slave
			ref_mem[4*i]   = i[7:0];
			ref_mem[4*i+1] = ~i[7:0];
			ref_mem[4*i+2] = i[7:0] ^ 8'ha5;
			ref_mem[4*i+3] = i[7:0] ^ 8'h3c;
		end
		repeat (8) @(negedge m_axil_clk);
		rst_n = 1'b1;
		@(negedge m_axil_clk);

		// Word writes, then word reads
		repeat (N_WORD) data_op(addr_t'(rand_below(192) * 4), $random(seed), `MEM_SIZE_WORD,
			1'b0, 1'b1);
		repeat (N_WORD) data_op(addr_t'(rand_below(192) * 4), '0, `MEM_SIZE_WORD, 1'b0, 1'b0);

		repeat (N_SUB) random_access(32'h300);

		// Both ports busy, data below 0x180 and fetch above
		fetch_since = 0;
		data_since  = 0;
		both_active = 1'b1;
		fork
			begin
				repeat (N_CONC) fetch_op(addr_t'(32'h180 + rand_below(96) * 4));
				both_active = 1'b0;
			end
			begin
				repeat (N_CONC) random_access(32'h180);
				both_active = 1'b0;
			end
		join

		// Misaligned, then read back the word it would have touched
		repeat (N_MIS) begin
			a = addr_t'(rand_below(32'h300)) | 32'd1;
			data_op(a, $random(seed), mem_size_t'(1 + rand_below(2)), 1'b0, 1'(rand_below(2)));
			data_op({a[31:2], 2'b00}, '0, `MEM_SIZE_WORD, 1'b0, 1'b0);
		end

		// Error region
		repeat (N_ERR - 4) data_op(addr_t'(32'h300 + rand_below(64) * 4), $random(seed),
			`MEM_SIZE_WORD, 1'b0, 1'(rand_below(2)));
		repeat (4) fetch_op(addr_t'(32'h300 + rand_below(64) * 4));

		repeat (N_FINAL) data_op(addr_t'(rand_below(192) * 4), '0, `MEM_SIZE_WORD, 1'b0, 1'b0);

		$display("No errors");
		$finish;
	end

endmodule

// File: hdl/mem_data_align.sv
// Little-endian lanes; halfwords need even and words need word-aligned addresses or they fail
`timescale 1ns/100ps
`include "mem_sys_settings.svh"

module mem_data_align
	import mem_sys_pkg::*;
(
	input  logic      m_axil_clk,
	input  logic      rst_n,

	input  data_req_t data_req,
	input  logic      data_valid,
	output word_rsp_t data_rsp,
	output logic      data_done,

	output word_req_t dreq,
	output logic      dreq_valid,
	input  word_rsp_t drsp,
	input  logic      drsp_done
);

	localparam int DW = `MEM_DATA_WIDTH;

	logic       misaligned;
	logic       mis_done;   // Error pulse for a rejected access
	logic [4:0] lane_shift; // Bit offset of the addressed lane
	data_t      lane_data;

	always_comb begin
		case (data_req.size)
			`MEM_SIZE_BYTE: misaligned = 1'b0;
			`MEM_SIZE_HALF: misaligned = data_req.addr[0];
			default:        misaligned = (data_req.addr[1:0] != 2'b00);
		endcase
	end

	assign lane_shift = {data_req.addr[1:0], 3'b000};

	////////////////////////////////////////////////////////////////////////////
	// Store path
	////////////////////////////////////////////////////////////////////////////

	assign dreq.addr  = {data_req.addr[`MEM_ADDR_WIDTH-1:2], 2'b00};
	assign dreq.wdata = data_req.wdata << lane_shift;
	assign dreq.wr    = data_req.wr;
	assign dreq_valid = data_valid && !misaligned;

	always_comb begin
		case (data_req.size)
			`MEM_SIZE_BYTE: dreq.be = strb_t'(4'b0001) << data_req.addr[1:0];
			`MEM_SIZE_HALF: dreq.be = strb_t'(4'b0011) << data_req.addr[1:0];
			default:        dreq.be = '1;
		endcase
	end

	// Held once, never repeated while the same request waits
	always_ff @(posedge m_axil_clk or negedge rst_n) begin
		if (!rst_n)
			mis_done <= 1'b0;
		else
			mis_done <= data_valid && misaligned && !mis_done;
	end

	////////////////////////////////////////////////////////////////////////////
	// Load path
	////////////////////////////////////////////////////////////////////////////

	assign lane_data = drsp.rdata >> lane_shift;

	always_comb begin
		data_rsp.err = drsp.err;
		case (data_req.size)
			`MEM_SIZE_BYTE: begin
				if (data_req.is_unsigned)
					data_rsp.rdata = {{(DW-8){1'b0}}, lane_data[7:0]};
				else
					data_rsp.rdata = {{(DW-8){lane_data[7]}}, lane_data[7:0]};
			end
			`MEM_SIZE_HALF: begin
				if (data_req.is_unsigned)
					data_rsp.rdata = {{(DW-16){1'b0}}, lane_data[15:0]};
				else
					data_rsp.rdata = {{(DW-16){lane_data[15]}}, lane_data[15:0]};
			end
			default: data_rsp.rdata = drsp.rdata;
		endcase
		if (mis_done) begin // Nothing came back from the bus
			data_rsp.rdata = '0;
			data_rsp.err   = 1'b1;
		end
	end

	assign data_done = mis_done || drsp_done;

endmodule

// File: hdl/mem_port_arbiter.sv
// One word access at a time; requesters must hold valid and request until their done pulse
`timescale 1ns/100ps
`include "mem_sys_settings.svh"

module mem_port_arbiter
	import mem_sys_pkg::*;
(
	input  logic      m_axil_clk,
	input  logic      rst_n,

	input  addr_t     fetch_addr,
	input  logic      fetch_valid,
	output word_rsp_t fetch_rsp,
	output logic      fetch_done,

	input  word_req_t dreq,
	input  logic      dreq_valid,
	output word_rsp_t drsp,
	output logic      drsp_done,

	output word_req_t word_req,
	output logic      word_valid,
	input  word_rsp_t word_rsp,
	input  logic      word_done
);

	typedef enum logic [1:0] {
		OWN_NONE,
		OWN_FETCH,
		OWN_DATA
	} owner_t;

	owner_t    owner;
	logic      last_data;  // Previous grant went to the data port
	logic      free;
	logic      pick_data;
	logic      pick_fetch;
	word_req_t fetch_word;

	// Fetch is a plain word read
	assign fetch_word.addr  = {fetch_addr[`MEM_ADDR_WIDTH-1:2], 2'b00};
	assign fetch_word.wdata = '0;
	assign fetch_word.be    = '1;
	assign fetch_word.wr    = 1'b0;

	// No new grant while a word is in flight or in its done cycle
	assign free       = (owner == OWN_NONE) && !word_done;
	assign pick_data  = free && dreq_valid && (!fetch_valid || !last_data);
	assign pick_fetch = free && fetch_valid && !pick_data;

	////////////////////////////////////////////////////////////////////////////
	// Grant state
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge m_axil_clk or negedge rst_n) begin
		if (!rst_n) begin
			owner     <= OWN_NONE;
			last_data <= 1'b0;
		end else if (word_done) begin
			owner <= OWN_NONE;
		end else if (pick_data) begin
			owner     <= OWN_DATA;
			last_data <= 1'b1;
		end else if (pick_fetch) begin
			owner     <= OWN_FETCH;
			last_data <= 1'b0;
		end
	end

	always_comb begin
		word_req   = fetch_word;
		word_valid = 1'b0;
		case (owner)
			OWN_FETCH: word_valid = fetch_valid && !word_done;
			OWN_DATA: begin
				word_req   = dreq;
				word_valid = dreq_valid && !word_done;
			end
			default: begin
				if (pick_data)
					word_req = dreq;
				word_valid = pick_data || pick_fetch;
			end
		endcase
	end

	// Responses go to both sides, done only to the owner
	assign fetch_rsp  = word_rsp;
	assign drsp       = word_rsp;
	assign fetch_done = word_done && (owner == OWN_FETCH);
	assign drsp_done  = word_done && (owner == OWN_DATA);

endmodule

// File: hdl/mem_sys.sv
// Fetch and data share one AXI-Lite master; each port keeps valid and request until done
`timescale 1ns/100ps

module mem_sys
	import mem_sys_pkg::*;
(
	input  logic       m_axil_clk,
	input  logic       rst_n,

	// Instruction fetch
	input  addr_t      fetch_addr,
	input  logic       fetch_valid,
	output word_rsp_t  fetch_rsp,
	output logic       fetch_done,

	// Loads and stores
	input  data_req_t  data_req,
	input  logic       data_valid,
	output word_rsp_t  data_rsp,
	output logic       data_done,

	output addr_t      m_axil_awaddr,
	output logic [2:0] m_axil_awprot,
	output logic       m_axil_awvalid,
	input  logic       m_axil_awready,
	output data_t      m_axil_wdata,
	output strb_t      m_axil_wstrb,
	output logic       m_axil_wvalid,
	input  logic       m_axil_wready,
	input  axil_resp_t m_axil_bresp,
	input  logic       m_axil_bvalid,
	output logic       m_axil_bready,
	output addr_t      m_axil_araddr,
	output logic [2:0] m_axil_arprot,
	output logic       m_axil_arvalid,
	input  logic       m_axil_arready,
	input  data_t      m_axil_rdata,
	input  axil_resp_t m_axil_rresp,
	input  logic       m_axil_rvalid,
	output logic       m_axil_rready
);

	word_req_t dreq;
	logic      dreq_valid;
	word_rsp_t drsp;
	logic      drsp_done;
	word_req_t word_req;   // Granted request into the master
	logic      word_valid;
	word_rsp_t word_rsp;
	logic      word_done;

	mem_data_align u_align (
		.m_axil_clk (m_axil_clk),
		.rst_n      (rst_n),
		.data_req   (data_req),
		.data_valid (data_valid),
		.data_rsp   (data_rsp),
		.data_done  (data_done),
		.dreq       (dreq),
		.dreq_valid (dreq_valid),
		.drsp       (drsp),
		.drsp_done  (drsp_done)
	);

	mem_port_arbiter u_arb (
		.m_axil_clk  (m_axil_clk),
		.rst_n       (rst_n),
		.fetch_addr  (fetch_addr),
		.fetch_valid (fetch_valid),
		.fetch_rsp   (fetch_rsp),
		.fetch_done  (fetch_done),
		.dreq        (dreq),
		.dreq_valid  (dreq_valid),
		.drsp        (drsp),
		.drsp_done   (drsp_done),
		.word_req    (word_req),
		.word_valid  (word_valid),
		.word_rsp    (word_rsp),
		.word_done   (word_done)
	);

	mem_sys_axil u_axil (
		.m_axil_clk     (m_axil_clk),
		.rst_n          (rst_n),
		.word_req       (word_req),
		.word_valid     (word_valid),
		.word_rsp       (word_rsp),
		.word_done      (word_done),
		.m_axil_awaddr  (m_axil_awaddr),
		.m_axil_awprot  (m_axil_awprot),
		.m_axil_awvalid (m_axil_awvalid),
		.m_axil_awready (m_axil_awready),
		.m_axil_wdata   (m_axil_wdata),
		.m_axil_wstrb   (m_axil_wstrb),
		.m_axil_wvalid  (m_axil_wvalid),
		.m_axil_wready  (m_axil_wready),
		.m_axil_bresp   (m_axil_bresp),
		.m_axil_bvalid  (m_axil_bvalid),
		.m_axil_bready  (m_axil_bready),
		.m_axil_araddr  (m_axil_araddr),
		.m_axil_arprot  (m_axil_arprot),
		.m_axil_arvalid (m_axil_arvalid),
		.m_axil_arready (m_axil_arready),
		.m_axil_rdata   (m_axil_rdata),
		.m_axil_rresp   (m_axil_rresp),
		.m_axil_rvalid  (m_axil_rvalid),
		.m_axil_rready  (m_axil_rready)
	);

endmodule

// File: hdl/mem_sys_axil.sv
// Single outstanding word access; a new request is taken only in IDLE, slave errors set err
`timescale 1ns/100ps
`include "mem_sys_settings.svh"

module mem_sys_axil
	import mem_sys_pkg::*;
(
	input  logic       m_axil_clk,
	input  logic       rst_n,

	input  word_req_t  word_req,
	input  logic       word_valid,
	output word_rsp_t  word_rsp,
	output logic       word_done,

	output addr_t      m_axil_awaddr,
	output logic [2:0] m_axil_awprot,
	output logic       m_axil_awvalid,
	input  logic       m_axil_awready,
	output data_t      m_axil_wdata,
	output strb_t      m_axil_wstrb,
	output logic       m_axil_wvalid,
	input  logic       m_axil_wready,
	input  axil_resp_t m_axil_bresp,
	input  logic       m_axil_bvalid,
	output logic       m_axil_bready,
	output addr_t      m_axil_araddr,
	output logic [2:0] m_axil_arprot,
	output logic       m_axil_arvalid,
	input  logic       m_axil_arready,
	input  data_t      m_axil_rdata,
	input  axil_resp_t m_axil_rresp,
	input  logic       m_axil_rvalid,
	output logic       m_axil_rready
);

	localparam axil_resp_t RESP_OKAY = 2'b00;

	axil_state_t state;
	axil_state_t nxt_state;
	word_req_t   req_q;     // Request held for the whole access
	logic        r_xfer;
	logic        b_xfer;

	assign r_xfer = m_axil_rvalid && m_axil_rready;
	assign b_xfer = m_axil_bvalid && m_axil_bready;

	////////////////////////////////////////////////////////////////////////////
	// State machine
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge m_axil_clk or negedge rst_n) begin
		if (!rst_n)
			state <= IDLE;
		else
			state <= nxt_state;
	end

	always_comb begin
		nxt_state = state;
		case (state)
			IDLE: begin
				if (word_valid)
					nxt_state = word_req.wr ? W_BOTH : R_ADDR;
			end
			R_ADDR: begin
				if (m_axil_arready)
					nxt_state = R_DATA;
			end
			R_DATA: begin
				if (m_axil_rvalid)
					nxt_state = IDLE;
			end
			W_BOTH: begin
				// Address and data channels may complete in either order
				case ({m_axil_awready, m_axil_wready})
					2'b11:   nxt_state = W_RESP;
					2'b10:   nxt_state = W_DATA; // Only data still pending
					2'b01:   nxt_state = W_ADDR;
					default: nxt_state = W_BOTH;
				endcase
			end
			W_ADDR: begin
				if (m_axil_awready)
					nxt_state = W_RESP;
			end
			W_DATA: begin
				if (m_axil_wready)
					nxt_state = W_RESP;
			end
			W_RESP: begin
				if (m_axil_bvalid)
					nxt_state = IDLE;
			end
			default: nxt_state = IDLE;
		endcase
	end

	////////////////////////////////////////////////////////////////////////////
	// Request and response registers
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge m_axil_clk) begin
		if (state == IDLE && word_valid)
			req_q <= word_req;
	end

	always_ff @(posedge m_axil_clk) begin
		if (r_xfer) begin
			word_rsp.rdata <= m_axil_rdata;
			word_rsp.err   <= (m_axil_rresp != RESP_OKAY);
		end else if (b_xfer) begin
			word_rsp.rdata <= '0;
			word_rsp.err   <= (m_axil_bresp != RESP_OKAY);
		end
	end

	// One cycle after the R or B transfer
	always_ff @(posedge m_axil_clk or negedge rst_n) begin
		if (!rst_n)
			word_done <= 1'b0;
		else
			word_done <= r_xfer || b_xfer;
	end

	////////////////////////////////////////////////////////////////////////////
	// Bus outputs
	////////////////////////////////////////////////////////////////////////////

	assign m_axil_awaddr  = req_q.addr;
	assign m_axil_awprot  = `MEM_AXIL_PROT;
	assign m_axil_awvalid = (state == W_BOTH) || (state == W_ADDR);
	assign m_axil_wdata   = req_q.wdata;
	assign m_axil_wstrb   = req_q.be;
	assign m_axil_wvalid  = (state == W_BOTH) || (state == W_DATA);
	assign m_axil_bready  = (state == W_RESP);

	assign m_axil_araddr  = req_q.addr;
	assign m_axil_arprot  = `MEM_AXIL_PROT;
	assign m_axil_arvalid = (state == R_ADDR);
	assign m_axil_rready  = (state == R_DATA);

endmodule

// File: hdl/mem_sys_pkg.sv
// Shared types; the settings header must be on the include path when this package compiles
`include "mem_sys_settings.svh"

package mem_sys_pkg;

	typedef logic [`MEM_ADDR_WIDTH-1:0]   addr_t;
	typedef logic [`MEM_DATA_WIDTH-1:0]   data_t;
	typedef logic [`MEM_DATA_WIDTH/8-1:0] strb_t;
	typedef logic [1:0]                   axil_resp_t;
	typedef logic [1:0]                   mem_size_t;

	// Sized request from the data side of the core
	typedef struct packed {
		addr_t     addr;
		data_t     wdata;
		mem_size_t size;
		logic      is_unsigned; // Zero-extend loads
		logic      wr;
	} data_req_t;

	// Word request on the internal port, address always word aligned
	typedef struct packed {
		addr_t addr;
		data_t wdata;
		strb_t be;
		logic  wr;
	} word_req_t;

	typedef struct packed {
		data_t rdata;
		logic  err; // Slave error or misaligned access
	} word_rsp_t;

	typedef enum logic [2:0] {
		IDLE,
		R_ADDR,
		R_DATA,
		W_BOTH,
		W_ADDR,
		W_DATA,
		W_RESP
	} axil_state_t;

endpackage

// File: hdl/mem_sys_settings.svh
// Bus widths are fixed at 32 bits; the aligner and arbiter assume four byte lanes per word
`ifndef MEM_SYS_SETTINGS_SVH
`define MEM_SYS_SETTINGS_SVH

////////////////////////////////////////////////////////////////////////////
// Bus geometry
////////////////////////////////////////////////////////////////////////////

`define MEM_ADDR_WIDTH 32 // Byte address
`define MEM_DATA_WIDTH 32 // One word per beat

// Unprivileged, secure, data access
`define MEM_AXIL_PROT 3'b000

////////////////////////////////////////////////////////////////////////////
// Access size codes on the data port
////////////////////////////////////////////////////////////////////////////

`define MEM_SIZE_BYTE 2'd0
`define MEM_SIZE_HALF 2'd1
`define MEM_SIZE_WORD 2'd2 // Code 3 is handled as a word

`endif

// File: mem_sys.f
+incdir+hdl
hdl/mem_sys_pkg.sv
hdl/mem_port_arbiter.sv
hdl/mem_data_align.sv
hdl/mem_sys_axil.sv
hdl/mem_sys.sv
bench/axil_mem_model.sv
bench/mem_sys_tb.sv
